// File: mem_port_macros.svh
`ifndef MEM_PORT_MACROS_SVH
`define MEM_PORT_MACROS_SVH

// byte address width on both sides
`define MP_ADDR_W 32

// one cache line
`define MP_LINE_W 256

// memory data path, one beat per cycle
`define MP_BEAT_W 64

// beats that make up one line
`define MP_BEATS 4

// two icaches plus two dcaches
`define MP_NREQ 4

// byte offset inside a line
`define MP_OFFSET_W 5

`endif

// File: mem_bus_pkg.sv
`default_nettype none

`include "mem_port_macros.svh"

package mem_bus_pkg;

    // line command toward memory
    // addr is line aligned, low offset bits are zero
    typedef struct packed {
        logic [`MP_ADDR_W-1:0] addr;
        logic                  read;
        logic                  write;
    } mem_cmd_t;

    // one read beat coming back from memory
    // every beat repeats the line address
    typedef struct packed {
        logic                  valid;
        logic [`MP_ADDR_W-1:0] addr;
        logic [`MP_BEAT_W-1:0] data;
    } mem_beat_t;

    // counts beats within one line
    typedef logic [$clog2(`MP_BEATS)-1:0] beat_idx_t;

endpackage

`default_nettype wire

// File: line_req_pkg.sv
`default_nettype none

`include "mem_port_macros.svh"

package line_req_pkg;

    // line request from one cache
    // held steady until its resp pulse
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [`MP_ADDR_W-1:0] addr;
        logic [`MP_LINE_W-1:0] wdata;
    } line_req_t;

    // resp is a single cycle pulse
    // rdata only meaningful during that pulse
    typedef struct packed {
        logic                  resp;
        logic [`MP_LINE_W-1:0] rdata;
    } line_resp_t;

    // index of one requester
    typedef logic [$clog2(`MP_NREQ)-1:0] req_idx_t;

    // one bit per requester
    typedef logic [`MP_NREQ-1:0] req_onehot_t;

endpackage

`default_nettype wire

// File: line_req_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module line_req_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  line_req_pkg::line_req_t     req [`MP_NREQ],
    input  wire logic                   issue_done,
    input  wire logic                   read_done,
    output logic                        grant_valid,
    output line_req_pkg::req_idx_t      grant_idx,
    output line_req_pkg::line_req_t     grant_req
);

    import line_req_pkg::*;

    // search starts here, one past the last served requester
    req_idx_t    ptr;
    req_onehot_t req_vld;
    logic        pick_found;
    req_idx_t    pick_idx;
    logic        done;

    always_comb begin
        for (int i = 0; i < `MP_NREQ; i++) begin
            req_vld[i] = req[i].valid;
        end
    end

    // first valid requester at or after ptr
    // walk offsets from the far end so the nearest one wins
    always_comb begin
        req_idx_t cand;
        pick_found = 1'b0;
        pick_idx   = ptr;
        cand       = ptr;
        for (int i = `MP_NREQ - 1; i >= 0; i--) begin
            cand = req_idx_t'((int'(ptr) + i) % `MP_NREQ);
            if (req_vld[cand]) begin
                pick_found = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    // either path ends the held grant
    assign done = issue_done | read_done;

    // grant state and rr pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            ptr         <= '0;
        end else if (grant_valid) begin
            if (done) begin
                grant_valid <= 1'b0;
                // skip past whoever was just served
                ptr         <= req_idx_t'((int'(grant_idx) + 1) % `MP_NREQ);
            end
        end else if (pick_found) begin
            grant_valid <= 1'b1;
        end
    end

    // latched copy of the winning request
    // stays fixed for the whole transaction
    always_ff @(posedge clk) begin
        if (!grant_valid && pick_found) begin
            grant_idx <= pick_idx;
            grant_req <= req[pick_idx];
        end
    end

    // write and read completion come from different stages
    // only one of them may close a transaction
    a_single_done : assert property (
        @(posedge clk) disable iff (rst)
        !(issue_done && read_done)
    );

    // done only arrives while a grant is held
    a_done_needs_grant : assert property (
        @(posedge clk) disable iff (rst)
        done |-> grant_valid
    );

endmodule

`default_nettype wire

// File: mem_cmd_issuer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module mem_cmd_issuer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   grant_valid,
    input  line_req_pkg::line_req_t     grant_req,
    input  wire logic                   mem_ready,
    output mem_bus_pkg::mem_cmd_t       mem_cmd,
    output logic [`MP_BEAT_W-1:0]       mem_wdata,
    output logic                        write_done
);

    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_WBEAT,
        ST_WAIT
    } issue_state_t;

    issue_state_t state;
    beat_idx_t    beat_cnt;
    logic         last_beat;
    logic         wr_active;

    assign last_beat = (beat_cnt == beat_idx_t'(`MP_BEATS - 1));

    // beat 0 rides with the accepted command, rest follow back to back
    assign wr_active = ((state == ST_CMD) && grant_req.write) || (state == ST_WBEAT);

    // command only while in ST_CMD
    always_comb begin
        mem_cmd       = '0;
        mem_cmd.addr  = {grant_req.addr[`MP_ADDR_W-1:`MP_OFFSET_W], {`MP_OFFSET_W{1'b0}}};
        mem_cmd.read  = (state == ST_CMD) && !grant_req.write;
        mem_cmd.write = (state == ST_CMD) && grant_req.write;
    end

    // low slice first
    always_comb begin
        mem_wdata = '0;
        if (wr_active) begin
            mem_wdata = grant_req.wdata[beat_cnt*`MP_BEAT_W +: `MP_BEAT_W];
        end
    end

    // high during the final beat, assembler registers it into resp
    assign write_done = (state == ST_WBEAT) && last_beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    beat_cnt <= '0;
                    if (grant_valid) state <= ST_CMD;
                end
                // hold the command until memory takes it
                ST_CMD: begin
                    if (mem_ready) begin
                        if (grant_req.write) begin
                            state    <= ST_WBEAT;
                            beat_cnt <= beat_idx_t'(1);
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WBEAT: begin
                    beat_cnt <= beat_cnt + beat_idx_t'(1);
                    if (last_beat) state <= ST_WAIT;
                end
                // wait for the arbiter to drop this grant
                ST_WAIT: begin
                    if (!grant_valid) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_no_rd_wr : assert property (
        @(posedge clk) disable iff (rst)
        !(mem_cmd.read && mem_cmd.write)
    );

    // a command or write beat never outlives the arbiter's grant
    a_cmd_in_grant : assert property (
        @(posedge clk) disable iff (rst)
        (mem_cmd.read || mem_cmd.write || write_done) |-> grant_valid
    );

endmodule

`default_nettype wire

// File: line_beat_assembler.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module line_beat_assembler (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   grant_valid,
    input  line_req_pkg::req_idx_t      grant_idx,
    input  line_req_pkg::line_req_t     grant_req,
    input  mem_bus_pkg::mem_beat_t      mem_beat,
    input  wire logic                   write_done,
    output line_req_pkg::line_resp_t    resp [`MP_NREQ],
    output logic                        read_done
);

    import mem_bus_pkg::*;
    import line_req_pkg::*;

    // first three beats, oldest in the low bits
    logic [`MP_LINE_W-`MP_BEAT_W-1:0] line_q;
    logic [`MP_LINE_W-1:0]            rdata_q;
    req_onehot_t                      resp_q;
    beat_idx_t                        beat_cnt;
    logic                             rd_active;
    logic                             addr_match;
    logic                             beat_take;
    logic                             last_beat;

    assign rd_active = grant_valid && !grant_req.write;

    // only beats for the granted line count
    assign addr_match = (mem_beat.addr[`MP_ADDR_W-1:`MP_OFFSET_W]
                         == grant_req.addr[`MP_ADDR_W-1:`MP_OFFSET_W]);

    assign beat_take = rd_active && mem_beat.valid && addr_match;
    assign last_beat = beat_take && (beat_cnt == beat_idx_t'(`MP_BEATS - 1));

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q    <= '0;
            read_done <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            resp_q    <= '0;
            read_done <= last_beat;
            // route the pulse to whoever holds the grant
            if (last_beat || write_done) begin
                resp_q[grant_idx] <= 1'b1;
            end
            // wraps back to zero after the fourth beat
            if (beat_take) begin
                beat_cnt <= beat_cnt + beat_idx_t'(1);
            end
        end
    end

    // data side, new beat enters at the top
    always_ff @(posedge clk) begin
        if (beat_take) begin
            line_q <= {mem_beat.data, line_q[`MP_LINE_W-`MP_BEAT_W-1:`MP_BEAT_W]};
        end
        if (last_beat) begin
            rdata_q <= {mem_beat.data, line_q};
        end
    end

    // one shared data register, only the pulsed requester looks at it
    always_comb begin
        for (int i = 0; i < `MP_NREQ; i++) begin
            resp[i].resp  = resp_q[i];
            resp[i].rdata = rdata_q;
        end
    end

    a_resp_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(resp_q)
    );

endmodule

`default_nettype wire

// File: line_mem_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module line_mem_port (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  line_req_pkg::line_req_t     req [`MP_NREQ],
    output line_req_pkg::line_resp_t    resp [`MP_NREQ],
    output mem_bus_pkg::mem_cmd_t       mem_cmd,
    output logic [`MP_BEAT_W-1:0]       mem_wdata,
    input  wire logic                   mem_ready,
    input  mem_bus_pkg::mem_beat_t      mem_beat
);

    import line_req_pkg::*;

    logic        grant_valid;
    req_idx_t    grant_idx;
    line_req_t   grant_req;
    logic        write_done;
    logic        read_done;
    logic        issue_done;
    req_onehot_t resp_bits;

    always_comb begin
        for (int i = 0; i < `MP_NREQ; i++) begin
            resp_bits[i] = resp[i].resp;
        end
    end

    // registered write resp, any resp pulse that is not a read completion
    assign issue_done = (|resp_bits) && !read_done;

    line_req_arbiter arb_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .issue_done  (issue_done),
        .read_done   (read_done),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_req   (grant_req)
    );

    mem_cmd_issuer issuer_i (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_req   (grant_req),
        .mem_ready   (mem_ready),
        .mem_cmd     (mem_cmd),
        .mem_wdata   (mem_wdata),
        .write_done  (write_done)
    );

    // both completion paths leave through here
    line_beat_assembler asm_i (
        .clk         (clk),
        .rst         (rst),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .grant_req   (grant_req),
        .mem_beat    (mem_beat),
        .write_done  (write_done),
        .resp        (resp),
        .read_done   (read_done)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module tb_mem_model (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  mem_bus_pkg::mem_cmd_t       mem_cmd,
    input  wire logic [`MP_BEAT_W-1:0]  mem_wdata,
    input  wire logic [2:0]             rnd_bits,
    output logic                        mem_ready,
    output mem_bus_pkg::mem_beat_t      mem_beat
);

    import mem_bus_pkg::*;

    // line store, unwritten lines read as zero
    logic [`MP_LINE_W-1:0] lines [logic [`MP_ADDR_W-1:0]];
    logic [`MP_LINE_W-1:0] wr_line;
    logic [`MP_ADDR_W-1:0] wr_addr;
    logic [`MP_ADDR_W-1:0] rd_addr;
    int                    wr_cnt;
    int                    rd_cnt;
    logic                  rd_pend;

    initial begin
        mem_ready = 1'b0;
        mem_beat  = '0;
        rd_pend   = 1'b0;
        wr_cnt    = 0;
    end

    // bus observed mid cycle
    always @(negedge clk) begin
        if (rst) begin
            wr_cnt  = 0;
            rd_pend = 1'b0;
        end else begin
            // beats 1 to 3 follow the accepted write
            if (wr_cnt != 0) begin
                wr_line[wr_cnt*`MP_BEAT_W +: `MP_BEAT_W] = mem_wdata;
                wr_cnt = wr_cnt + 1;
                if (wr_cnt == `MP_BEATS) begin
                    lines[wr_addr] = wr_line;
                    wr_cnt = 0;
                end
            end
            if (mem_ready && mem_cmd.write) begin
                wr_addr = mem_cmd.addr;
                wr_line[`MP_BEAT_W-1:0] = mem_wdata;
                wr_cnt = 1;
            end
            if (mem_ready && mem_cmd.read) begin
                rd_addr = mem_cmd.addr;
                rd_cnt  = 0;
                rd_pend = 1'b1;
            end else if (mem_beat.valid) begin
                rd_cnt  = rd_cnt + 1;
                rd_pend = (rd_cnt < `MP_BEATS);
            end
        end
    end

    always @(posedge clk) begin : drive_bus
        logic [2:0]            rnd;
        logic                  rst_seen;
        logic [`MP_LINE_W-1:0] line;
        rnd      = rnd_bits;
        rst_seen = rst;
        #1;
        // not ready about one cycle in four
        mem_ready = !rst_seen && (rnd[1:0] != 2'b00);
        mem_beat  = '0;
        // about half the cycles of a read are gaps
        if (!rst_seen && rd_pend && !rnd[2]) begin
            line = lines.exists(rd_addr) ? lines[rd_addr] : '0;
            mem_beat.valid = 1'b1;
            mem_beat.addr  = rd_addr;
            mem_beat.data  = line[rd_cnt*`MP_BEAT_W +: `MP_BEAT_W];
        end
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module tb_checker (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  line_req_pkg::line_req_t     req [`MP_NREQ],
    input  line_req_pkg::line_resp_t    resp [`MP_NREQ],
    input  mem_bus_pkg::mem_cmd_t       mem_cmd,
    input  wire logic [`MP_BEAT_W-1:0]  mem_wdata,
    input  wire logic                   mem_ready,
    input  mem_bus_pkg::mem_beat_t      mem_beat,
    output int                          err_data,
    output int                          err_order,
    output int                          err_proto,
    output int                          txn_done
);

    import mem_bus_pkg::*;
    import line_req_pkg::*;

    localparam int CAT_DATA  = 0;
    localparam int CAT_ORDER = 1;
    localparam int CAT_PROTO = 2;

    typedef enum int {PH_IDLE, PH_CMD, PH_WBEAT, PH_RBEAT, PH_RESP} chk_phase_t;

    // expected memory contents, updated at each write resp
    logic [`MP_LINE_W-1:0] store [logic [`MP_ADDR_W-1:0]];
    chk_phase_t phase;
    req_idx_t   ptr;
    req_idx_t   cur_idx;
    line_req_t  cur_req;
    mem_cmd_t   exp_cmd;
    mem_cmd_t   held_cmd;
    logic       stalled;
    logic       rst_q;
    int         beat_n;

    initial begin
        err_data  = 0;
        err_order = 0;
        err_proto = 0;
        txn_done  = 0;
    end

    function automatic logic [`MP_LINE_W-1:0] line_at(input logic [`MP_ADDR_W-1:0] a);
        line_at = store.exists(a) ? store[a] : '0;
    endfunction

    task automatic bump_count(input int cat);
        if (cat == CAT_DATA) err_data++;
        else if (cat == CAT_ORDER) err_order++;
        else err_proto++;
    endtask

    task automatic value_error(input string sig, input logic [`MP_LINE_W-1:0] exp_v,
                               input logic [`MP_LINE_W-1:0] act_v, input int cat);
        $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
        bump_count(cat);
    endtask

    task automatic protocol_error(input string what);
        $display("[ERROR] t=%0t %s", $time, what);
        bump_count(CAT_PROTO);
    endtask

    always @(negedge clk) begin : check_cycle
        req_onehot_t resp_bits;
        chk_phase_t  cur;
        logic        cmd_vis;
        logic        found;
        req_idx_t    cand;
        for (int i = 0; i < `MP_NREQ; i++) begin
            resp_bits[i] = resp[i].resp;
        end
        cmd_vis = mem_cmd.read || mem_cmd.write;
        cur     = phase;
        // quiet in reset and the cycle after
        if ((rst || rst_q) && (cmd_vis || resp_bits != '0)) begin
            protocol_error("resp or memory command active in or just after reset");
        end
        rst_q = rst;
        if (rst) begin
            phase   = PH_IDLE;
            ptr     = '0;
            stalled = 1'b0;
        end else begin
            if (cmd_vis && cur != PH_CMD) begin
                protocol_error("memory command outside a granted transaction");
            end
            if (resp_bits != '0 && cur != PH_RESP) begin
                value_error("resp", '0, resp_bits, CAT_PROTO);
            end
            case (cur)
                PH_IDLE: begin
                    // round robin, first valid at or after ptr
                    found = 1'b0;
                    for (int i = 0; i < `MP_NREQ; i++) begin
                        cand = req_idx_t'(ptr + i);
                        if (!found && req[cand].valid) begin
                            found   = 1'b1;
                            cur_idx = cand;
                        end
                    end
                    if (found) begin
                        cur_req       = req[cur_idx];
                        exp_cmd.addr  = {cur_req.addr[`MP_ADDR_W-1:`MP_OFFSET_W],
                                         {`MP_OFFSET_W{1'b0}}};
                        exp_cmd.read  = !cur_req.write;
                        exp_cmd.write = cur_req.write;
                        stalled       = 1'b0;
                        phase         = PH_CMD;
                    end
                end
                PH_CMD: begin
                    if (cmd_vis) begin
                        // region bits name the served requester
                        if (mem_cmd.addr[9:8] != cur_idx) begin
                            value_error("mem_cmd.addr[9:8]", cur_idx, mem_cmd.addr[9:8],
                                        CAT_ORDER);
                        end
                        if (mem_cmd != exp_cmd) begin
                            value_error("mem_cmd", exp_cmd, mem_cmd, CAT_PROTO);
                        end
                        if (stalled && mem_cmd != held_cmd) begin
                            value_error("mem_cmd while stalled", held_cmd, mem_cmd, CAT_PROTO);
                        end
                        held_cmd = mem_cmd;
                        stalled  = !mem_ready;
                        beat_n   = 0;
                        if (mem_ready) begin
                            phase = cur_req.write ? PH_WBEAT : PH_RBEAT;
                        end
                    end else if (stalled) begin
                        protocol_error("command withdrawn before memory accepted it");
                    end
                end
                PH_RBEAT: begin
                    if (mem_beat.valid && mem_beat.addr == exp_cmd.addr) begin
                        beat_n++;
                        if (beat_n == `MP_BEATS) phase = PH_RESP;
                    end
                end
                PH_RESP: begin
                    if (resp_bits != req_onehot_t'(1 << cur_idx)) begin
                        value_error("resp", 1 << cur_idx, resp_bits, CAT_PROTO);
                    end
                    if (cur_req.write) begin
                        store[exp_cmd.addr] = cur_req.wdata;
                    end else if (resp[cur_idx].rdata != line_at(exp_cmd.addr)) begin
                        value_error($sformatf("resp[%0d].rdata", cur_idx),
                                    line_at(exp_cmd.addr), resp[cur_idx].rdata, CAT_DATA);
                    end
                    txn_done++;
                    ptr   = cur_idx + 1'b1;
                    phase = PH_IDLE;
                end
                default: begin
                end
            endcase
            // write beats from the acceptance cycle on, low slice first
            if (phase == PH_WBEAT) begin
                if (mem_wdata != cur_req.wdata[beat_n*`MP_BEAT_W +: `MP_BEAT_W]) begin
                    value_error($sformatf("mem_wdata beat %0d", beat_n),
                                cur_req.wdata[beat_n*`MP_BEAT_W +: `MP_BEAT_W], mem_wdata,
                                CAT_DATA);
                end
                beat_n++;
                if (beat_n == `MP_BEATS) phase = PH_RESP;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_line_mem_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "mem_port_macros.svh"

module tb_line_mem_port;

    import mem_bus_pkg::*;
    import line_req_pkg::*;

    // first few requests per cache come back to back, all four held valid
    localparam int TXN_PER_REQ = 60;
    localparam int BURST_TXNS  = 10;
    localparam int WATCHDOG_NS = 300 * 40 * 8;

    logic                  clk = 1'b0;
    logic                  rst;
    line_req_t             req [`MP_NREQ];
    line_resp_t            resp [`MP_NREQ];
    mem_cmd_t              mem_cmd;
    logic [`MP_BEAT_W-1:0] mem_wdata;
    logic                  mem_ready;
    mem_beat_t             mem_beat;
    logic [2:0]            mem_rnd;
    logic [31:0]           lfsr_q;
    int                    served [`MP_NREQ];
    int                    err_data;
    int                    err_order;
    int                    err_proto;
    int                    txn_done;

    always #4 clk = ~clk;

    line_mem_port dut_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .resp      (resp),
        .mem_cmd   (mem_cmd),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_beat  (mem_beat)
    );

    tb_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_cmd   (mem_cmd),
        .mem_wdata (mem_wdata),
        .rnd_bits  (mem_rnd),
        .mem_ready (mem_ready),
        .mem_beat  (mem_beat)
    );

    tb_checker chk_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .resp      (resp),
        .mem_cmd   (mem_cmd),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_beat  (mem_beat),
        .err_data  (err_data),
        .err_order (err_order),
        .err_proto (err_proto),
        .txn_done  (txn_done)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [`MP_LINE_W-1:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q  = lfsr_step(lfsr_q);
            bits[i] = lfsr_q[0];
        end
    endtask

    // requester k owns addresses with bits 9:8 equal to k
    task automatic new_request(input int k);
        logic [`MP_LINE_W-1:0] r;
        req[k] = '0;
        take_bits(1, r);
        req[k].write = r[0];
        // eight lines per region so reads hit earlier writes
        take_bits(8, r);
        req[k].addr = {{(`MP_ADDR_W-10){1'b0}}, 2'(k), r[7:0]};
        if (req[k].write) begin
            take_bits(`MP_LINE_W, r);
            req[k].wdata = r;
        end
        req[k].valid = 1'b1;
    endtask

    initial begin : stimulus
        logic [`MP_LINE_W-1:0] r;
        logic                  all_done;
        lfsr_q  = 32'd55;
        rst     = 1'b1;
        mem_rnd = '0;
        for (int k = 0; k < `MP_NREQ; k++) begin
            req[k]    = '0;
            served[k] = 0;
        end
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        all_done = 1'b0;
        while (!all_done) begin
            @(posedge clk);
            #1;
            all_done = 1'b1;
            for (int k = 0; k < `MP_NREQ; k++) begin
                // resp pulse closes the held request
                if (req[k].valid && resp[k].resp) begin
                    req[k].valid = 1'b0;
                    served[k]++;
                end
                if (!req[k].valid && served[k] < TXN_PER_REQ) begin
                    take_bits(1, r);
                    if (served[k] < BURST_TXNS || r[0]) begin
                        new_request(k);
                    end
                end
                if (served[k] < TXN_PER_REQ) begin
                    all_done = 1'b0;
                end
            end
            // ready and gap choices for the memory model
            take_bits(3, r);
            mem_rnd = r[2:0];
        end
        repeat (4) @(posedge clk);
        $display("errors: data %0d, order %0d, protocol %0d; transactions %0d of %0d",
                 err_data, err_order, err_proto, txn_done, `MP_NREQ * TXN_PER_REQ);
        if (err_data + err_order + err_proto == 0 && txn_done == `MP_NREQ * TXN_PER_REQ) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // bound of 300 transactions at 40 cycles each
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, only %0d transactions completed", txn_done);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
mem_bus_pkg.sv
line_req_pkg.sv
line_req_arbiter.sv
mem_cmd_issuer.sv
line_beat_assembler.sv
line_mem_port.sv
tb_mem_model.sv
tb_checker.sv
tb_line_mem_port.sv
